// File: include/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// datapath and register file sizing
`define RV_XLEN        32
`define RV_REG_ADDR_W  5
`define RV_REG_COUNT   32

// base opcodes, bits [6:0]
`define RV_OP_R        7'b0110011
`define RV_OP_ALUI     7'b0010011
`define RV_OP_LOAD     7'b0000011
`define RV_OP_JALR     7'b1100111
`define RV_OP_STORE    7'b0100011
`define RV_OP_BRANCH   7'b1100011
`define RV_OP_LUI      7'b0110111
`define RV_OP_AUIPC    7'b0010111
`define RV_OP_JAL      7'b1101111
`define RV_OP_CSR      7'b1110011
`define RV_OP_FENCE    7'b0001111

// alu operation codes
`define RV_ALU_W       4
`define RV_ALU_ADD     4'd0
`define RV_ALU_SUB     4'd1
`define RV_ALU_SLL     4'd2
`define RV_ALU_SLT     4'd3
`define RV_ALU_SLTU    4'd4
`define RV_ALU_XOR     4'd5
`define RV_ALU_SRL     4'd6
`define RV_ALU_SRA     4'd7
`define RV_ALU_OR      4'd8
`define RV_ALU_AND     4'd9
`define RV_ALU_PASSB   4'd10

`endif

// File: source/rv_core_pipe.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_core_pipe (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_valid,
	input  rv_pkg::instr_u       in_instr,
	input  logic [`RV_XLEN-1:0]  in_pc,
	output rv_pkg::result_t      res
);

	rv_pkg::dec_t               dec;
	rv_pkg::opnd_t              opnd;
	logic [`RV_REG_ADDR_W-1:0]  rd_addr_a;
	logic [`RV_REG_ADDR_W-1:0]  rd_addr_b;
	logic [`RV_XLEN-1:0]        rd_data_a;
	logic [`RV_XLEN-1:0]        rd_data_b;

	rv_decode rv_decode_i (
		.clk      (clk),
		.reset    (reset),
		.in_valid (in_valid),
		.in_instr (in_instr),
		.in_pc    (in_pc),
		.dec      (dec)
	);

	// writeback comes straight from the execute result
	rv_regfile rv_regfile_i (
		.clk       (clk),
		.reset     (reset),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.wr_en     (res.write),
		.wr_addr   (res.rd),
		.wr_data   (res.data),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b)
	);

	rv_operand rv_operand_i (
		.clk       (clk),
		.reset     (reset),
		.dec       (dec),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.opnd      (opnd)
	);

	rv_execute rv_execute_i (
		.clk   (clk),
		.reset (reset),
		.opnd  (opnd),
		.res   (res)
	);

endmodule

// File: source/rv_decode.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_decode (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_valid,
	input  rv_pkg::instr_u       in_instr,
	input  logic [`RV_XLEN-1:0]  in_pc,
	output rv_pkg::dec_t         dec
);

	rv_pkg::ctrl_t        ctrl;
	logic [`RV_XLEN-1:0]  imm;

	// shared funct3 map for register and immediate forms
	function automatic logic [`RV_ALU_W-1:0] alu_code(input logic [2:0] funct3,
			input logic alt);
		case (funct3)
			3'b000: alu_code = alt ? `RV_ALU_SUB : `RV_ALU_ADD;
			3'b001: alu_code = `RV_ALU_SLL;
			3'b010: alu_code = `RV_ALU_SLT;
			3'b011: alu_code = `RV_ALU_SLTU;
			3'b100: alu_code = `RV_ALU_XOR;
			3'b101: alu_code = alt ? `RV_ALU_SRA : `RV_ALU_SRL;
			3'b110: alu_code = `RV_ALU_OR;
			default: alu_code = `RV_ALU_AND;
		endcase
	endfunction

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = `RV_ALU_ADD;
		case (in_instr.r.opcode)
			`RV_OP_R: begin
				ctrl.write_reg = 1'b1;
				ctrl.alu_op = alu_code(in_instr.r.funct3, in_instr.r.funct7[5]);
			end
			`RV_OP_ALUI: begin
				ctrl.write_reg = 1'b1;
				ctrl.alu_src = 1'b1;
				// no subi, only srai reads the funct7 bit
				ctrl.alu_op = alu_code(in_instr.i.funct3,
					(in_instr.i.funct3 == 3'b101) && in_instr.r.funct7[5]);
			end
			`RV_OP_LUI: begin
				ctrl.write_reg = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.lui = 1'b1;
				ctrl.alu_op = `RV_ALU_PASSB;
			end
			`RV_OP_AUIPC: begin
				ctrl.write_reg = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.use_pc = 1'b1;
			end
			`RV_OP_JAL: begin
				ctrl.write_reg = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.use_pc = 1'b1;
				ctrl.jal = 1'b1;
			end
			`RV_OP_JALR: begin
				// alu forms rs1 + imm for the target
				ctrl.write_reg = 1'b1;
				ctrl.alu_src = 1'b1;
				ctrl.jalr = 1'b1;
			end
			`RV_OP_BRANCH: begin
				ctrl.branch = 1'b1;
			end
			`RV_OP_LOAD, `RV_OP_STORE, `RV_OP_CSR, `RV_OP_FENCE: begin
				// recognized but not executed here
				ctrl.unsupported = 1'b1;
			end
			default: begin
				ctrl.unsupported = 1'b1;
			end
		endcase
	end

	// immediate assembly per format
	always_comb begin
		case (in_instr.r.opcode)
			`RV_OP_STORE: begin
				imm = {{(`RV_XLEN-12){in_instr.s.imm_hi[6]}},
					in_instr.s.imm_hi, in_instr.s.imm_lo};
			end
			`RV_OP_BRANCH: begin
				imm = {{(`RV_XLEN-13){in_instr.b.imm_12}}, in_instr.b.imm_12,
					in_instr.b.imm_11, in_instr.b.imm_10_5, in_instr.b.imm_4_1, 1'b0};
			end
			`RV_OP_LUI, `RV_OP_AUIPC: begin
				imm = {in_instr.u.imm_31_12, 12'd0};
			end
			`RV_OP_JAL: begin
				imm = {{(`RV_XLEN-21){in_instr.j.imm_20}}, in_instr.j.imm_20,
					in_instr.j.imm_19_12, in_instr.j.imm_11, in_instr.j.imm_10_1, 1'b0};
			end
			default: begin
				// i form, also covers alui, jalr and load
				imm = {{(`RV_XLEN-12){in_instr.i.imm[11]}}, in_instr.i.imm};
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			dec.valid <= 1'b0;
		end else begin
			dec.valid <= in_valid;
		end
		dec.pc <= in_pc;
		dec.rd <= in_instr.r.rd;
		dec.rs1 <= in_instr.r.rs1;
		dec.rs2 <= in_instr.r.rs2;
		dec.funct3 <= in_instr.r.funct3;
		dec.ctrl <= ctrl;
		dec.imm <= imm;
	end

endmodule

// File: source/rv_execute.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_execute (
	input  logic           clk,
	input  logic           reset,
	input  rv_pkg::opnd_t  opnd,
	output rv_pkg::result_t res
);

	logic [4:0]           shamt;
	logic [`RV_XLEN-1:0]  alu_res;
	logic                 taken;
	logic [`RV_XLEN-1:0]  link;
	logic [`RV_XLEN-1:0]  pc_target;
	logic [`RV_XLEN-1:0]  target;
	logic [`RV_XLEN-1:0]  wb_data;
	logic                 do_write;
	logic                 do_redirect;

	assign shamt = opnd.b[4:0];

	always_comb begin
		case (opnd.ctrl.alu_op)
			`RV_ALU_ADD:   alu_res = opnd.a + opnd.b;
			`RV_ALU_SUB:   alu_res = opnd.a - opnd.b;
			`RV_ALU_SLL:   alu_res = opnd.a << shamt;
			`RV_ALU_SLT:   alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(opnd.a) < $signed(opnd.b)};
			`RV_ALU_SLTU:  alu_res = {{(`RV_XLEN-1){1'b0}}, opnd.a < opnd.b};
			`RV_ALU_XOR:   alu_res = opnd.a ^ opnd.b;
			`RV_ALU_SRL:   alu_res = opnd.a >> shamt;
			`RV_ALU_SRA:   alu_res = $signed(opnd.a) >>> shamt;
			`RV_ALU_OR:    alu_res = opnd.a | opnd.b;
			`RV_ALU_AND:   alu_res = opnd.a & opnd.b;
			`RV_ALU_PASSB: alu_res = opnd.b;
			default:       alu_res = '0;
		endcase
	end

	// rs1 rides in operand a for branches
	always_comb begin
		case (opnd.funct3)
			3'b000:  taken = (opnd.a == opnd.rs2_val);
			3'b001:  taken = (opnd.a != opnd.rs2_val);
			3'b100:  taken = ($signed(opnd.a) < $signed(opnd.rs2_val));
			3'b101:  taken = ($signed(opnd.a) >= $signed(opnd.rs2_val));
			3'b110:  taken = (opnd.a < opnd.rs2_val);
			3'b111:  taken = (opnd.a >= opnd.rs2_val);
			default: taken = 1'b0;
		endcase
	end

	assign link = opnd.pc + `RV_XLEN'd4;
	assign pc_target = opnd.pc + opnd.imm;

	// jalr target is rs1 + imm with bit 0 forced low
	assign target = opnd.ctrl.jalr ? {alu_res[`RV_XLEN-1:1], 1'b0} : pc_target;
	assign wb_data = (opnd.ctrl.jal || opnd.ctrl.jalr) ? link : alu_res;

	assign do_write = opnd.ctrl.write_reg && (opnd.rd != '0);
	assign do_redirect = opnd.ctrl.jal || opnd.ctrl.jalr || (opnd.ctrl.branch && taken);

	always_ff @(posedge clk) begin
		if (reset) begin
			res.valid <= 1'b0;
			res.write <= 1'b0;
			res.redirect <= 1'b0;
			res.unsupported <= 1'b0;
		end else begin
			res.valid <= opnd.valid;
			res.write <= opnd.valid && do_write;
			res.redirect <= opnd.valid && do_redirect;
			res.unsupported <= opnd.valid && opnd.ctrl.unsupported;
		end
		res.rd <= opnd.rd;
		res.data <= wb_data;
		res.target <= target;
	end

endmodule

// File: source/rv_operand.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_operand (
	input  logic                       clk,
	input  logic                       reset,
	input  rv_pkg::dec_t               dec,
	input  logic [`RV_XLEN-1:0]        rd_data_a,
	input  logic [`RV_XLEN-1:0]        rd_data_b,
	output logic [`RV_REG_ADDR_W-1:0]  rd_addr_a,
	output logic [`RV_REG_ADDR_W-1:0]  rd_addr_b,
	output rv_pkg::opnd_t              opnd
);

	logic [`RV_XLEN-1:0] op_a;
	logic [`RV_XLEN-1:0] op_b;

	assign rd_addr_a = dec.rs1;
	assign rd_addr_b = dec.rs2;

	always_comb begin
		// auipc and jal add to the pc, lui adds to zero
		if (dec.ctrl.use_pc) begin
			op_a = dec.pc;
		end else if (dec.ctrl.lui) begin
			op_a = '0;
		end else begin
			op_a = rd_data_a;
		end
		op_b = dec.ctrl.alu_src ? dec.imm : rd_data_b;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			opnd.valid <= 1'b0;
		end else begin
			opnd.valid <= dec.valid;
		end
		opnd.pc <= dec.pc;
		opnd.rd <= dec.rd;
		opnd.funct3 <= dec.funct3;
		opnd.ctrl <= dec.ctrl;
		opnd.a <= op_a;
		opnd.b <= op_b;
		// kept for the branch compare
		opnd.rs2_val <= rd_data_b;
		opnd.imm <= dec.imm;
	end

endmodule

// File: source/rv_pkg.sv
`include "rv_cfg.svh"

package rv_pkg;

	// raw instruction formats, msb first
	typedef struct packed {
		logic [6:0]                  funct7;
		logic [`RV_REG_ADDR_W-1:0]   rs2;
		logic [`RV_REG_ADDR_W-1:0]   rs1;
		logic [2:0]                  funct3;
		logic [`RV_REG_ADDR_W-1:0]   rd;
		logic [6:0]                  opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0]                 imm;
		logic [`RV_REG_ADDR_W-1:0]   rs1;
		logic [2:0]                  funct3;
		logic [`RV_REG_ADDR_W-1:0]   rd;
		logic [6:0]                  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0]                  imm_hi;
		logic [`RV_REG_ADDR_W-1:0]   rs2;
		logic [`RV_REG_ADDR_W-1:0]   rs1;
		logic [2:0]                  funct3;
		logic [4:0]                  imm_lo;
		logic [6:0]                  opcode;
	} s_fmt_t;

	typedef struct packed {
		logic                        imm_12;
		logic [5:0]                  imm_10_5;
		logic [`RV_REG_ADDR_W-1:0]   rs2;
		logic [`RV_REG_ADDR_W-1:0]   rs1;
		logic [2:0]                  funct3;
		logic [3:0]                  imm_4_1;
		logic                        imm_11;
		logic [6:0]                  opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0]                 imm_31_12;
		logic [`RV_REG_ADDR_W-1:0]   rd;
		logic [6:0]                  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic                        imm_20;
		logic [9:0]                  imm_10_1;
		logic                        imm_11;
		logic [7:0]                  imm_19_12;
		logic [`RV_REG_ADDR_W-1:0]   rd;
		logic [6:0]                  opcode;
	} j_fmt_t;

	// one instruction word, six ways to read it
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_u;

	typedef struct packed {
		logic                  write_reg;
		logic                  alu_src;
		logic                  use_pc;
		logic                  branch;
		logic                  jal;
		logic                  jalr;
		logic                  lui;
		logic                  unsupported;
		logic [`RV_ALU_W-1:0]  alu_op;
	} ctrl_t;

	typedef struct packed {
		logic                        valid;
		logic [`RV_XLEN-1:0]         pc;
		logic [`RV_REG_ADDR_W-1:0]   rd;
		logic [`RV_REG_ADDR_W-1:0]   rs1;
		logic [`RV_REG_ADDR_W-1:0]   rs2;
		logic [2:0]                  funct3;
		ctrl_t                       ctrl;
		logic [`RV_XLEN-1:0]         imm;
	} dec_t;

	typedef struct packed {
		logic                        valid;
		logic [`RV_XLEN-1:0]         pc;
		logic [`RV_REG_ADDR_W-1:0]   rd;
		logic [2:0]                  funct3;
		ctrl_t                       ctrl;
		logic [`RV_XLEN-1:0]         a;
		logic [`RV_XLEN-1:0]         b;
		logic [`RV_XLEN-1:0]         rs2_val;
		logic [`RV_XLEN-1:0]         imm;
	} opnd_t;

	typedef struct packed {
		logic                        valid;
		logic                        write;
		logic [`RV_REG_ADDR_W-1:0]   rd;
		logic [`RV_XLEN-1:0]         data;
		logic                        redirect;
		logic [`RV_XLEN-1:0]         target;
		logic                        unsupported;
	} result_t;

endpackage

// File: source/rv_regfile.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_regfile (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`RV_REG_ADDR_W-1:0]  rd_addr_a,
	input  logic [`RV_REG_ADDR_W-1:0]  rd_addr_b,
	input  logic                       wr_en,
	input  logic [`RV_REG_ADDR_W-1:0]  wr_addr,
	input  logic [`RV_XLEN-1:0]        wr_data,
	output logic [`RV_XLEN-1:0]        rd_data_a,
	output logic [`RV_XLEN-1:0]        rd_data_b
);

	logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

	// x0 first, then the write-through bypass, then the array
	function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_ADDR_W-1:0] addr);
		if (addr == '0) begin
			read_port = '0;
		end else if (wr_en && (wr_addr == addr)) begin
			read_port = wr_data;
		end else begin
			read_port = regs[addr];
		end
	endfunction

	assign rd_data_a = read_port(rd_addr_a);
	assign rd_data_b = read_port(rd_addr_b);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `RV_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

endmodule

// File: tb/rv_core_pipe_tb.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module rv_core_pipe_tb;

	localparam int TIMEOUT_CYCLES = 20;
	// driven at one edge, result out three edges later, seen at the fourth falling edge
	localparam int RESULT_NEGEDGES = 4;

	logic                 clk;
	logic                 reset;
	logic                 in_valid;
	rv_pkg::instr_u       in_instr;
	logic [`RV_XLEN-1:0]  in_pc;
	rv_pkg::result_t      res;

	// architectural shadow of the register file
	logic [`RV_XLEN-1:0]  model_regs [`RV_REG_COUNT];
	rv_pkg::result_t      exp_q [$];
	string                name_q [$];
	int                   issue_q [$];
	rv_pkg::result_t      got_q [$];
	int                   got_cyc_q [$];
	int                   negedges;
	integer               seed;
	logic [`RV_XLEN-1:0]  pc_next;

	rv_core_pipe rv_core_pipe_i (
		.clk      (clk),
		.reset    (reset),
		.in_valid (in_valid),
		.in_instr (in_instr),
		.in_pc    (in_pc),
		.res      (res)
	);

	always #50 clk = ~clk;

	// results are sampled mid-cycle away from the clock edge
	always @(negedge clk) begin
		negedges = negedges + 1;
		if (!reset && res.valid) begin
			got_q.push_back(res);
			got_cyc_q.push_back(negedges);
		end
	end

	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, `RV_OP_R};
	endfunction

	function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
	endfunction

	function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
	endfunction

	function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
	endfunction

	function automatic logic [`RV_XLEN-1:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// RV32I integer semantics where alt picks sub and sra
	function automatic logic [`RV_XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [`RV_XLEN-1:0] a, input logic [`RV_XLEN-1:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 1 : 0;
			3'd3: return (a < b) ? 1 : 0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt) begin
					return $unsigned($signed(a) >>> b[4:0]);
				end else begin
					return a >> b[4:0];
				end
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3,
			input logic [`RV_XLEN-1:0] a, input logic [`RV_XLEN-1:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic rv_pkg::result_t expect_res(input logic write, input logic [4:0] rd,
			input logic [`RV_XLEN-1:0] data, input logic redirect,
			input logic [`RV_XLEN-1:0] target, input logic unsupported);
		rv_pkg::result_t r;
		r = '0;
		r.valid = 1'b1;
		r.write = write;
		r.rd = rd;
		r.data = data;
		r.redirect = redirect;
		r.target = target;
		r.unsupported = unsupported;
		return r;
	endfunction

	function automatic logic [4:0] pick_reg();
		return ({$random(seed)} % 9) + 1;
	endfunction

	task automatic write_model(input logic [4:0] rd, input logic [`RV_XLEN-1:0] value);
		if (rd != 0) begin
			model_regs[rd] = value;
		end
	endtask

	task automatic check_word(input logic [`RV_XLEN-1:0] got, input logic [`RV_XLEN-1:0] exp,
			input string msg);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
			$display("Finished with errors");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_result(input rv_pkg::result_t got, input rv_pkg::result_t exp,
			input string name);
		check_word(got.write, exp.write, {name, " write"});
		check_word(got.redirect, exp.redirect, {name, " redirect"});
		check_word(got.unsupported, exp.unsupported, {name, " unsupported"});
		// rd and data matter only on a write and target only on a redirect
		if (exp.write) begin
			check_word(got.rd, exp.rd, {name, " rd"});
			check_word(got.data, exp.data, {name, " data"});
		end
		if (exp.redirect) begin
			check_word(got.target, exp.target, {name, " target"});
		end
	endtask

	task automatic report_timeout(input string name);
		$display("timeout at %0t ns: no result arrived for %s", $time, name);
		$display("Finished with errors");
		$fatal(1, "pipeline stopped responding");
	endtask

	task automatic issue_word(input logic [31:0] word, input rv_pkg::result_t exp,
			input string name, input int gap);
		@(posedge clk);
		in_valid <= 1'b1;
		in_instr <= word;
		in_pc <= pc_next;
		exp_q.push_back(exp);
		name_q.push_back(name);
		issue_q.push_back(negedges);
		pc_next = pc_next + 4;
		repeat (gap) begin
			@(posedge clk);
			in_valid <= 1'b0;
		end
	endtask

	task automatic issue_r(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2);
		logic [`RV_XLEN-1:0] value;
		value = alu_ref(f3, f7[5], model_regs[rs1], model_regs[rs2]);
		issue_word(r_word(f7, rs2, rs1, f3, rd), expect_res(rd != 0, rd, value, 1'b0, '0, 1'b0),
			$sformatf("r-type f7=%h f3=%0d rd=x%0d", f7, f3, rd), 1);
		write_model(rd, value);
	endtask

	task automatic issue_i(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm, input int gap);
		logic [`RV_XLEN-1:0] value;
		value = alu_ref(f3, (f3 == 3'd5) && imm[10], model_regs[rs1], sext12(imm));
		issue_word(i_word(imm, rs1, f3, rd, `RV_OP_ALUI),
			expect_res(rd != 0, rd, value, 1'b0, '0, 1'b0),
			$sformatf("i-type f3=%0d rd=x%0d imm=%h", f3, rd, imm), gap);
		write_model(rd, value);
	endtask

	task automatic issue_upper(input logic is_lui, input logic [4:0] rd, input logic [19:0] imm);
		logic [`RV_XLEN-1:0] value;
		value = is_lui ? {imm, 12'd0} : pc_next + {imm, 12'd0};
		issue_word(u_word(imm, rd, is_lui ? `RV_OP_LUI : `RV_OP_AUIPC),
			expect_res(rd != 0, rd, value, 1'b0, '0, 1'b0),
			$sformatf("%s rd=x%0d imm=%h", is_lui ? "lui" : "auipc", rd, imm), 1);
		write_model(rd, value);
	endtask

	task automatic issue_jal(input logic [4:0] rd, input logic [20:0] off);
		logic [`RV_XLEN-1:0] target;
		target = pc_next + {{11{off[20]}}, off[20:1], 1'b0};
		issue_word(j_word(off, rd), expect_res(rd != 0, rd, pc_next + 4, 1'b1, target, 1'b0),
			$sformatf("jal rd=x%0d", rd), 1);
		write_model(rd, pc_next);
	endtask

	task automatic issue_jalr(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		logic [`RV_XLEN-1:0] target;
		target = (model_regs[rs1] + sext12(imm)) & ~32'd1;
		issue_word(i_word(imm, rs1, 3'd0, rd, `RV_OP_JALR),
			expect_res(rd != 0, rd, pc_next + 4, 1'b1, target, 1'b0),
			$sformatf("jalr rd=x%0d rs1=x%0d imm=%h", rd, rs1, imm), 1);
		write_model(rd, pc_next);
	endtask

	task automatic issue_branch(input logic [2:0] f3, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [12:0] off);
		logic                 taken;
		logic [`RV_XLEN-1:0]  target;
		taken = branch_taken(f3, model_regs[rs1], model_regs[rs2]);
		target = pc_next + {{19{off[12]}}, off[12:1], 1'b0};
		issue_word(b_word(off, rs2, rs1, f3), expect_res(1'b0, 0, '0, taken, target, 1'b0),
			$sformatf("branch f3=%0d x%0d x%0d", f3, rs1, rs2), 1);
	endtask

	task automatic issue_unsupported(input logic [31:0] word, input string name);
		issue_word(word, expect_res(1'b0, 0, '0, 1'b0, '0, 1'b1), name, 0);
	endtask

	task automatic collect_results();
		rv_pkg::result_t  got;
		rv_pkg::result_t  exp;
		string            name;
		int               issued;
		int               waited;
		@(posedge clk);
		in_valid <= 1'b0;
		while (exp_q.size() > 0) begin
			waited = 0;
			while (got_q.size() == 0 && waited < TIMEOUT_CYCLES) begin
				@(posedge clk);
				waited++;
			end
			if (got_q.size() == 0) begin
				report_timeout(name_q[0]);
			end else begin
				got = got_q.pop_front();
				exp = exp_q.pop_front();
				name = name_q.pop_front();
				issued = issue_q.pop_front();
				check_word(got_cyc_q.pop_front(), issued + RESULT_NEGEDGES, {name, " arrival"});
				check_result(got, exp, name);
			end
		end
	endtask

	task automatic test_alu_ops();
		logic [4:0] shamt;
		for (int r = 1; r <= 3; r++) begin
			issue_upper(1'b1, r, $random(seed));
			issue_i(3'd0, r, r, $random(seed), 1);
		end
		// x4 kept negative for sra and signed compares
		issue_upper(1'b1, 4, 20'hf0f0f);
		issue_i(3'd0, 4, 4, $random(seed), 1);
		for (int f3 = 0; f3 < 8; f3++) begin
			issue_r(7'h00, f3, 5 + f3, pick_reg(), pick_reg());
		end
		issue_r(7'h20, 3'd0, 13, pick_reg(), pick_reg());
		issue_r(7'h20, 3'd5, 14, 4, pick_reg());
		issue_i(3'd0, 15, 0, 12'hfff, 1);
		issue_r(7'h00, 3'd3, 16, 1, 15);
		issue_r(7'h20, 3'd0, 17, 16, 5);
		for (int f3 = 0; f3 < 8; f3++) begin
			if (f3 != 1 && f3 != 5) begin
				issue_i(f3, 24 + f3, pick_reg(), $random(seed), 1);
			end
		end
		shamt = $random(seed);
		issue_i(3'd1, 25, pick_reg(), {7'h00, shamt}, 1);
		issue_i(3'd5, 29, 4, {7'h00, shamt}, 1);
		issue_i(3'd5, 21, 4, {7'h20, shamt}, 1);
		collect_results();
	endtask

	task automatic test_x0();
		issue_i(3'd0, 0, 1, 12'h123, 1);
		issue_r(7'h00, 3'd0, 0, 2, 3);
		issue_r(7'h00, 3'd6, 18, 0, 0);
		issue_i(3'd0, 19, 0, 12'h7ff, 1);
		collect_results();
	endtask

	task automatic test_upper();
		for (int n = 0; n < 3; n++) begin
			pc_next = {$random(seed)} & 32'hffff_fffc;
			issue_upper(1'b1, 20, $random(seed));
			issue_upper(1'b0, 21, $random(seed));
		end
		collect_results();
	endtask

	task automatic test_jumps();
		issue_jal(22, $random(seed));
		issue_jal(0, $random(seed));
		issue_i(3'd0, 23, 0, 12'h101, 1);
		issue_jalr(24, 23, 12'h022);
		issue_jalr(25, 4, $random(seed) | 1);
		issue_jalr(0, 2, $random(seed));
		collect_results();
	endtask

	task automatic test_branches();
		issue_i(3'd0, 20, 0, 12'hffd, 1);
		issue_i(3'd0, 21, 0, 12'h002, 1);
		issue_i(3'd0, 22, 0, 12'h005, 1);
		issue_i(3'd0, 23, 0, 12'h005, 1);
		// equal, unequal, and both orders across the sign boundary
		for (int f3 = 0; f3 < 8; f3++) begin
			if (f3 != 2 && f3 != 3) begin
				issue_branch(f3, 22, 23, $random(seed));
				issue_branch(f3, 22, 21, $random(seed));
				issue_branch(f3, 20, 21, $random(seed));
				issue_branch(f3, 21, 20, $random(seed));
			end
		end
		collect_results();
	endtask

	task automatic test_back_to_back_and_unsupported();
		for (int n = 0; n < 4; n++) begin
			issue_i(3'd0, 26 + n, 0, $random(seed), 0);
		end
		issue_i(3'd4, 30, 1, $random(seed), 0);
		issue_unsupported(i_word(12'h010, 1, 3'd2, 5, `RV_OP_LOAD), "load");
		issue_unsupported(s_word(12'h024, 2, 1, 3'd2), "store");
		issue_unsupported(i_word(12'h300, 1, 3'd1, 6, `RV_OP_CSR), "csr");
		issue_unsupported(i_word(12'h0ff, 0, 3'd0, 7, `RV_OP_FENCE), "fence");
		issue_unsupported({25'h1a5a5a5, 7'b1111011}, "unknown opcode");
		collect_results();
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_instr = '0;
		in_pc = '0;
		negedges = 0;
		seed = 32'hd926;
		pc_next = 32'h0000_1000;
		for (int r = 0; r < `RV_REG_COUNT; r++) begin
			model_regs[r] = '0;
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_word(res.valid, 1'b0, "valid after reset");
		check_word(res.write, 1'b0, "write after reset");
		check_word(res.redirect, 1'b0, "redirect after reset");
		check_word(res.unsupported, 1'b0, "unsupported after reset");
		test_alu_ops();
		test_x0();
		test_upper();
		test_jumps();
		test_branches();
		test_back_to_back_and_unsupported();
		repeat (6) @(posedge clk);
		check_word(got_q.size(), 0, "results with no matching instruction");
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+include
source/rv_pkg.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_operand.sv
source/rv_execute.sv
source/rv_core_pipe.sv
tb/rv_core_pipe_tb.sv
